// ==== common/slurm16_pkg.sv ====
// SLURM16 operand stage package.
// Holds the word widths, the instruction classes, the special register
// numbers and the packed types that travel between the decoder, the
// register file, the hazard check and the output register.

package slurm16_pkg;

	// Width of a data word and of an instruction word.
	localparam int data_bits = 16;

	// Width of a register number and the size of the register file.
	localparam int reg_bits = 4;
	localparam int num_regs = 16;

	// Width of the class field at the top of every instruction.
	localparam int class_bits = 4;

	// Width of the two low nibbles that hold an ALU source, an immediate
	// or a memory offset.
	localparam int field_bits = 4;

	// Register r0 always reads as zero and is never written.
	localparam logic [reg_bits-1:0] zero_register = 4'd0;

	// The return instruction reads the link register.
	localparam logic [reg_bits-1:0] link_register = 4'd15;

	// The return-from-interrupt instruction reads this one instead.
	localparam logic [reg_bits-1:0] interrupt_link_register = 4'd14;

	// Instruction classes, taken from bits [15:12] of the instruction.
	// Classes that span two codes use the low code bit as part of an
	// immediate or a condition, so both codes decode the same way here.
	typedef enum logic [class_bits-1:0] {
		class_nop             = 4'd0,
		class_ret_iret        = 4'd1,
		class_alu_single      = 4'd2,
		class_alu_reg_reg     = 4'd3,
		class_cond_mov        = 4'd4,
		class_three_reg_cond  = 4'd5,
		class_alu_imm_lo      = 4'd6,
		class_alu_imm_hi      = 4'd7,
		class_branch_lo       = 4'd8,
		class_branch_hi       = 4'd9,
		class_load_store      = 4'd10,
		class_byte_load_store = 4'd11,
		class_byte_load_sx    = 4'd12,
		class_peek_poke       = 4'd13,
		class_unused_lo       = 4'd14,
		class_unused_hi       = 4'd15
	} ins_class_t;

	// ALU format. Bits [11:8] carry the ALU operation.
	// The branch format shares this layout, with its index register in dest.
	typedef struct packed {
		ins_class_t             ins_class;
		logic [field_bits-1:0]  alu_op;
		logic [reg_bits-1:0]    dest;
		logic [field_bits-1:0]  src_or_imm;
	} ins_alu_t;

	// Memory format. Bits [11:8] carry the index register.
	typedef struct packed {
		ins_class_t             ins_class;
		logic [reg_bits-1:0]    idx;
		logic [reg_bits-1:0]    dest;
		logic [field_bits-1:0]  offset;
	} ins_mem_t;

	// One instruction word, seen through either format or as raw bits.
	typedef union packed {
		ins_alu_t               alu;
		ins_mem_t               mem;
		logic [data_bits-1:0]   raw;
	} ins_word_t;

	// Register selects for the two read ports.
	typedef struct packed {
		logic [reg_bits-1:0]    a_sel;
		logic [reg_bits-1:0]    b_sel;
	} reg_sel_t;

	// Writeback port of the register file.
	typedef struct packed {
		logic                   valid;
		logic [reg_bits-1:0]    reg_num;
		logic [data_bits-1:0]   data;
	} reg_write_t;

	// A destination that a later pipeline stage has yet to write back.
	typedef struct packed {
		logic                   valid;
		logic [reg_bits-1:0]    reg_num;
	} pending_t;

	// What the stage hands to execute.
	typedef struct packed {
		ins_word_t              instruction;
		logic [data_bits-1:0]   a_value;
		logic [data_bits-1:0]   b_value;
	} operand_t;

endpackage

// ==== decode/slurm16_cpu_decode.sv ====
// SLURM16 instruction decoder.
// Works out which two registers an instruction reads, so that the
// register file can fetch them and the hazard check can look for
// results that are still on their way.

`timescale 1ns/1ps

module slurm16_cpu_decode (
	input  slurm16_pkg::ins_word_t ins,
	output slurm16_pkg::reg_sel_t  sel
);

	import slurm16_pkg::*;

	always_comb begin
		// Both ports read r0 unless the class says otherwise.
		sel.a_sel = zero_register;
		sel.b_sel = zero_register;

		// The class nibble sits in the same place in every format, so
		// either union member gives the same value here.
		case (ins.alu.ins_class)
			class_nop: begin
				// Nothing to read.
			end
			class_ret_iret: begin
				// Bit 0 picks the interrupt return.
				if (ins.raw[0]) begin
					sel.a_sel = interrupt_link_register;
				end else begin
					sel.a_sel = link_register;
				end
			end
			class_alu_single: begin
				// Single operand ALU ops only need the source.
				sel.b_sel = ins.alu.src_or_imm;
			end
			class_alu_reg_reg, class_cond_mov, class_three_reg_cond: begin
				// Register to register forms read both dest and src.
				sel.a_sel = ins.alu.dest;
				sel.b_sel = ins.alu.src_or_imm;
			end
			class_alu_imm_lo, class_alu_imm_hi: begin
				// The low nibble is an immediate, so only dest is a register.
				sel.a_sel = ins.alu.dest;
			end
			class_branch_lo, class_branch_hi: begin
				// The branch index register sits where an ALU dest would.
				sel.a_sel = ins.alu.dest;
			end
			class_load_store, class_byte_load_store, class_byte_load_sx: begin
				// Memory forms address through idx plus an offset.
				sel.a_sel = ins.mem.dest;
				sel.b_sel = ins.mem.idx;
			end
			class_peek_poke: begin
				// I/O access uses the same layout as memory access.
				sel.a_sel = ins.mem.dest;
				sel.b_sel = ins.mem.idx;
			end
			default: begin
				// Unused classes read nothing.
			end
		endcase
	end

endmodule

// ==== regfile/slurm16_register_file.sv ====
// SLURM16 register file.
// Sixteen 16-bit registers with two combinational read ports and one
// write port. A read of the register being written returns the new data,
// and r0 always reads zero.

`timescale 1ns/1ps

module slurm16_register_file (
	input  logic                                clk,
	input  logic                                rst_n,
	input  slurm16_pkg::reg_sel_t               sel,
	input  slurm16_pkg::reg_write_t             wr,
	output logic [slurm16_pkg::data_bits-1:0]   a_value,
	output logic [slurm16_pkg::data_bits-1:0]   b_value
);

	import slurm16_pkg::*;

	logic [data_bits-1:0] regs [num_regs];

	// One read port. The incoming write is forwarded so that a register
	// written and read in the same cycle gives its new value.
	function automatic logic [data_bits-1:0] read_port(
		input logic [reg_bits-1:0] sel_num
	);
		logic [data_bits-1:0] value;
		if (sel_num == zero_register) begin
			value = '0;
		end else if (wr.valid && (wr.reg_num == sel_num)) begin
			value = wr.data;
		end else begin
			value = regs[sel_num];
		end
		return value;
	endfunction

	// Writes to r0 are dropped, so it stays at its reset value.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.valid && (wr.reg_num != zero_register)) begin
			regs[wr.reg_num] <= wr.data;
		end
	end

	// Port A feeds the first operand and port B the second.
	assign a_value = read_port(sel.a_sel);
	assign b_value = read_port(sel.b_sel);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the operand stage testbench with Verilator and runs it.
# The run counts as passed only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f vlog.f --top-module slurm16_operand_tb -Mdir obj_dir \
	&& ./obj_dir/Vslurm16_operand_tb | tee "$log" \
	|| { echo "build or simulation run did not complete"; exit 1; }

grep -q "^PASS: all tests$" "$log" \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed, see $log"; exit 1; }

// ==== verification/operand_input.txt ====
# test valid ins wr_valid wr_reg wr_data pex_valid pex_reg pmem_valid pmem_reg ready exp_a exp_b
# All fields after the test number are hex. A ready of 0 means a hazard must block the step.
1 0 0000 1 1 1111 0 0 0 0 0 0000 0000
1 0 0000 1 2 2222 0 0 0 0 0 0000 0000
1 0 0000 1 3 3333 0 0 0 0 0 0000 0000
1 0 0000 1 4 4444 0 0 0 0 0 0000 0000
1 0 0000 1 5 5555 0 0 0 0 0 0000 0000
1 0 0000 1 6 6666 0 0 0 0 0 0000 0000
1 0 0000 1 7 7777 0 0 0 0 0 0000 0000
1 0 0000 1 e eeee 0 0 0 0 0 0000 0000
1 0 0000 1 f ffff 0 0 0 0 0 0000 0000
2 1 0345 0 0 0000 0 0 0 0 1 0000 0000
2 1 1000 0 0 0000 0 0 0 0 1 ffff 0000
2 1 1001 0 0 0000 0 0 0 0 1 eeee 0000
2 1 2a13 0 0 0000 0 0 0 0 1 0000 3333
2 1 3012 0 0 0000 0 0 0 0 1 1111 2222
2 1 4034 0 0 0000 0 0 0 0 1 3333 4444
2 1 5156 0 0 0000 0 0 0 0 1 5555 6666
2 1 6275 0 0 0000 0 0 0 0 1 7777 0000
2 1 7f24 0 0 0000 0 0 0 0 1 2222 0000
2 1 8049 0 0 0000 0 0 0 0 1 4444 0000
2 1 9356 0 0 0000 0 0 0 0 1 5555 0000
2 1 a263 0 0 0000 0 0 0 0 1 6666 2222
2 1 b517 0 0 0000 0 0 0 0 1 1111 5555
2 1 c74f 0 0 0000 0 0 0 0 1 4444 7777
2 1 d3f2 0 0 0000 0 0 0 0 1 ffff 3333
2 1 e123 0 0 0000 0 0 0 0 1 0000 0000
2 1 f456 0 0 0000 0 0 0 0 1 0000 0000
3 1 3030 1 3 abcd 0 0 0 0 1 abcd 0000
3 1 3000 1 0 dead 0 0 0 0 1 0000 0000
3 1 4003 0 0 0000 0 0 0 0 1 0000 abcd
4 1 3012 0 0 0000 1 2 0 0 0 0000 0000
4 1 3012 0 0 0000 1 2 0 0 0 0000 0000
4 1 3012 0 0 0000 0 0 1 1 0 0000 0000
4 1 3012 0 0 0000 1 0 1 0 1 1111 2222
4 1 2012 0 0 0000 1 0 0 0 1 0000 2222
5 1 3456 0 0 0000 0 0 0 0 1 5555 6666
5 1 a713 0 0 0000 0 0 0 0 1 1111 7777
5 1 3550 1 5 0f0f 0 0 0 0 1 0f0f 0000
5 1 4005 0 0 0000 0 0 0 0 1 0000 0f0f

// ==== verification/slurm16_operand_checker.sv ====
// SLURM16 operand stage checker.
// Watches the stage ports and queues the expected operands of every accepted
// instruction, then compares them with what leaves the stage. It also checks
// in_ready, the state after reset and the hold rule under back-pressure.

`timescale 1ns/1ps

module slurm16_operand_checker (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               in_valid,
	input  logic                               in_ready,
	input  slurm16_pkg::ins_word_t             in_ins,
	input  logic                               out_valid,
	input  logic                               out_ready,
	input  slurm16_pkg::operand_t              out_op,
	input  logic                               exp_ready,
	input  logic [slurm16_pkg::data_bits-1:0]  exp_a,
	input  logic [slurm16_pkg::data_bits-1:0]  exp_b,
	input  logic [7:0]                         test_num,
	input  logic                               test_end,
	input  logic                               all_done,
	output logic                               idle,
	output int                                 error_count
);

	import slurm16_pkg::*;

	operand_t expect_q [$];
	operand_t held_op;
	logic     held;
	logic     seen_accept;
	int       test_errors;
	int       tests_run;
	int       tests_failed;

	task automatic count_error();
		error_count++;
		test_errors++;
	endtask

	task automatic compare_field(input string name, input logic [15:0] want,
		input logic [15:0] got);
		if (got !== want) begin
			$display("error at %0t ns: %s expected %h got %h", $time, name, want, got);
			count_error();
		end
	endtask

	// Values are read at the rising edge, before the DUT registers update.
	always @(posedge clk) begin
		operand_t want;
		operand_t entry;
		logic     want_ready;
		if (!rst_n) begin
			expect_q.delete();
			held         = 1'b0;
			held_op      = '0;
			seen_accept  = 1'b0;
			error_count  = 0;
			test_errors  = 0;
			tests_run    = 0;
			tests_failed = 0;
			idle         = 1'b1;
		end else begin
			// Nothing may appear on the output before the first instruction goes in.
			if (out_valid && !seen_accept) begin
				$display("out_valid went high at %0t ns before any instruction was accepted",
					$time);
				count_error();
			end
			// An entry that execute did not take must stay exactly as it was.
			if (held) begin
				if (!out_valid) begin
					$display("out_valid dropped at %0t ns while out_ready was low", $time);
					count_error();
				end else if (out_op != held_op) begin
					$display("error at %0t ns: out_op expected %h got %h", $time, held_op, out_op);
					count_error();
				end
			end
			// The slot is full while an accepted instruction has yet to leave.
			// The step says whether a hazard blocks the input.
			want_ready = exp_ready && ((expect_q.size() == 0) || out_ready);
			if (in_valid && (in_ready !== want_ready)) begin
				$display("error at %0t ns: in_ready expected %b got %b", $time,
					want_ready, in_ready);
				count_error();
			end
			if (out_valid && out_ready) begin
				if (expect_q.size() == 0) begin
					$display("an instruction left the stage at %0t ns with none outstanding", $time);
					count_error();
				end else begin
					want = expect_q.pop_front();
					compare_field("out_op.instruction", want.instruction.raw, out_op.instruction.raw);
					compare_field("out_op.a_value", want.a_value, out_op.a_value);
					compare_field("out_op.b_value", want.b_value, out_op.b_value);
				end
			end
			// The new entry is queued after the output check so it cannot match itself.
			if (in_valid && in_ready) begin
				entry.instruction = in_ins;
				entry.a_value     = exp_a;
				entry.b_value     = exp_b;
				expect_q.push_back(entry);
				seen_accept = 1'b1;
			end
			held    = out_valid && !out_ready;
			held_op = out_op;
			idle    = (expect_q.size() == 0);
			if (test_end) begin
				tests_run++;
				if (test_errors == 0) begin
					$display("test %0d passed", test_num);
				end else begin
					$display("test %0d failed with %0d errors", test_num, test_errors);
					tests_failed++;
				end
				test_errors = 0;
			end
			if (all_done) begin
				$display("%0d tests run, %0d failed, %0d errors in total",
					tests_run, tests_failed, error_count);
			end
		end
	end

endmodule

// ==== verification/slurm16_operand_tb.sv ====
// SLURM16 operand stage testbench.
// Replays the steps of the stimulus file on the falling clock edge. It stands
// in for fetch on the input side and for the later stages on the writeback and
// pending ports, while execute takes results at random.

`timescale 1ns/1ps

module slurm16_operand_tb;

	import slurm16_pkg::*;

	localparam int max_steps = 64;

	// One line of the stimulus file.
	typedef struct packed {
		logic [7:0]            test;
		logic                  in_valid;
		ins_word_t             ins;
		reg_write_t            wr;
		pending_t              pend_ex;
		pending_t              pend_mem;
		logic                  exp_ready;
		logic [data_bits-1:0]  exp_a;
		logic [data_bits-1:0]  exp_b;
	} step_t;

	logic                  clk;
	logic                  rst_n;
	logic                  in_valid;
	logic                  in_ready;
	ins_word_t             in_ins;
	reg_write_t            wr;
	pending_t              pend_ex;
	pending_t              pend_mem;
	logic                  out_valid;
	logic                  out_ready;
	operand_t              out_op;
	logic                  exp_ready;
	logic [data_bits-1:0]  exp_a;
	logic [data_bits-1:0]  exp_b;
	logic [7:0]            test_num;
	logic                  test_end;
	logic                  all_done;
	logic                  idle;
	int                    error_count;
	step_t                 steps [max_steps];
	int                    num_steps;
	logic                  load_done;
	int                    seed = 47;

	slurm16_operand_stage dut_i (
		.clk (clk), .rst_n (rst_n), .in_valid (in_valid), .in_ready (in_ready),
		.in_ins (in_ins), .wr (wr), .pend_ex (pend_ex), .pend_mem (pend_mem),
		.out_valid (out_valid), .out_ready (out_ready), .out_op (out_op)
	);

	slurm16_operand_checker checker_i (
		.clk (clk), .rst_n (rst_n), .in_valid (in_valid), .in_ready (in_ready),
		.in_ins (in_ins), .out_valid (out_valid), .out_ready (out_ready), .out_op (out_op),
		.exp_ready (exp_ready), .exp_a (exp_a), .exp_b (exp_b), .test_num (test_num),
		.test_end (test_end), .all_done (all_done), .idle (idle), .error_count (error_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Execute takes a result on about three cycles out of four.
	initial begin
		out_ready = 1'b0;
		forever begin
			@(negedge clk);
			out_ready = ($random(seed) & 3) != 0;
		end
	end

	// Reads every step line, skipping comments, into the step table.
	task automatic load_steps();
		int    fd;
		int    f [13];
		string line;
		fd = $fopen("verification/operand_input.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file verification/operand_input.txt");
		end else begin
			while (!$feof(fd) && num_steps < max_steps) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.getc(0) != "#" &&
					$sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6],
						f[7], f[8], f[9], f[10], f[11], f[12]) == 13) begin
					steps[num_steps].test      = f[0][7:0];
					steps[num_steps].in_valid  = f[1][0];
					steps[num_steps].ins       = f[2][15:0];
					steps[num_steps].wr        = {f[3][0], f[4][3:0], f[5][15:0]};
					steps[num_steps].pend_ex   = {f[6][0], f[7][3:0]};
					steps[num_steps].pend_mem  = {f[8][0], f[9][3:0]};
					steps[num_steps].exp_ready = f[10][0];
					steps[num_steps].exp_a     = f[11][15:0];
					steps[num_steps].exp_b     = f[12][15:0];
					num_steps++;
				end
			end
			$fclose(fd);
			if (num_steps == 0) begin
				$display("the stimulus file held no steps");
			end
		end
	endtask

	// Puts one step on the DUT inputs and tells the checker what to expect.
	task automatic apply_step(input step_t s);
		in_valid  = s.in_valid;
		in_ins    = s.ins;
		wr        = s.wr;
		pend_ex   = s.pend_ex;
		pend_mem  = s.pend_mem;
		exp_ready = s.exp_ready;
		exp_a     = s.exp_a;
		exp_b     = s.exp_b;
		test_num  = s.test;
	endtask

	// Drops the inputs, lets every accepted instruction leave the stage, then
	// marks the test as finished for one cycle.
	task automatic end_test();
		@(negedge clk);
		in_valid       = 1'b0;
		wr.valid       = 1'b0;
		pend_ex.valid  = 1'b0;
		pend_mem.valid = 1'b0;
		while (!idle) @(negedge clk);
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
	endtask

	initial begin
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_ins    = '0;
		wr        = '0;
		pend_ex   = '0;
		pend_mem  = '0;
		exp_ready = 1'b0;
		exp_a     = '0;
		exp_b     = '0;
		test_num  = '0;
		test_end  = 1'b0;
		all_done  = 1'b0;
		num_steps = 0;
		load_done = 1'b0;
		load_steps();
		load_done = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < num_steps; i++) begin
			@(negedge clk);
			apply_step(steps[i]);
			@(posedge clk);
			// An instruction that should go in stays on the inputs until it does.
			// A step that expects a stall lasts exactly one cycle.
			if (steps[i].in_valid && steps[i].exp_ready) begin
				while (!in_ready) @(posedge clk);
			end
			if (i == num_steps - 1 || steps[i + 1].test != steps[i].test) begin
				end_test();
			end
		end
		@(negedge clk);
		all_done = 1'b1;
		@(negedge clk);
		all_done = 1'b0;
		if (error_count == 0 && num_steps > 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// Watchdog. Each step gets a generous share of cycles, plus slack for reset.
	initial begin
		wait (load_done);
		repeat (num_steps * 20 + 100) @(posedge clk);
		$display("timed out after %0d cycles, the stage stopped making progress",
			num_steps * 20 + 100);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== verilog/slurm16_hazard_check.sv ====
// SLURM16 operand hazard check.
// Compares the two register selects against the destinations that the
// execute and memory stages still have to write back, and stalls the
// stage while any of them matches.

`timescale 1ns/1ps

module slurm16_hazard_check (
	input  slurm16_pkg::reg_sel_t  sel,
	input  slurm16_pkg::pending_t  pend_ex,
	input  slurm16_pkg::pending_t  pend_mem,
	output logic                   stall
);

	import slurm16_pkg::*;

	logic a_hit;
	logic b_hit;

	// True when a pending write will change the selected register.
	// r0 is never written, so waiting on it would only lose cycles.
	function automatic logic depends_on(
		input logic [reg_bits-1:0] sel_num,
		input pending_t            pend
	);
		return pend.valid && (sel_num != zero_register) && (pend.reg_num == sel_num);
	endfunction

	// Each port checks both later stages.
	assign a_hit = depends_on(sel.a_sel, pend_ex) || depends_on(sel.a_sel, pend_mem);
	assign b_hit = depends_on(sel.b_sel, pend_ex) || depends_on(sel.b_sel, pend_mem);

	// The instruction waits if either of its operands is stale.
	assign stall = a_hit || b_hit;

endmodule

// ==== verilog/slurm16_operand_latch.sv ====
// SLURM16 operand output register.
// Holds the single output slot of the stage. It accepts an instruction
// when the operands are safe to read and the slot is free, and keeps
// the slot steady while execute applies back-pressure.

`timescale 1ns/1ps

module slurm16_operand_latch (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                in_valid,
	output logic                                in_ready,
	input  slurm16_pkg::ins_word_t              in_ins,
	input  logic [slurm16_pkg::data_bits-1:0]   a_value,
	input  logic [slurm16_pkg::data_bits-1:0]   b_value,
	input  logic                                stall,
	output logic                                out_valid,
	input  logic                                out_ready,
	output slurm16_pkg::operand_t               out_op
);

	logic slot_free;
	logic load;

	// The slot can take a new entry when it is empty or its current
	// entry leaves on this edge.
	assign slot_free = !out_valid || out_ready;

	// A pending hazard blocks acceptance even when the slot is free.
	assign in_ready = slot_free && !stall;

	// An input transfer happens on this edge.
	assign load = in_valid && in_ready;

	// Slot occupancy.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (load) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			// The entry left and nothing replaced it.
			out_valid <= 1'b0;
		end
	end

	// Payload is only loaded on a transfer, so it holds while execute
	// keeps out_ready low.
	always_ff @(posedge clk) begin
		if (load) begin
			out_op.instruction <= in_ins;
			out_op.a_value     <= a_value;
			out_op.b_value     <= b_value;
		end
	end

endmodule

// ==== verilog/slurm16_operand_stage.sv ====
// SLURM16 operand stage.
// Decodes the register selects of an incoming instruction, reads both
// operands from the register file, waits out pending writebacks and
// hands the instruction with its operands to execute one cycle later.

`timescale 1ns/1ps

module slurm16_operand_stage (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  slurm16_pkg::ins_word_t   in_ins,
	input  slurm16_pkg::reg_write_t  wr,
	input  slurm16_pkg::pending_t    pend_ex,
	input  slurm16_pkg::pending_t    pend_mem,
	output logic                     out_valid,
	input  logic                     out_ready,
	output slurm16_pkg::operand_t    out_op
);

	import slurm16_pkg::*;

	// Selects from the decoder, shared by the register file and the
	// hazard check.
	reg_sel_t              sel;
	logic [data_bits-1:0]  a_value;
	logic [data_bits-1:0]  b_value;
	logic                  stall;

	slurm16_cpu_decode decode_i (
		.ins (in_ins),
		.sel (sel)
	);

	slurm16_register_file register_file_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.sel     (sel),
		.wr      (wr),
		.a_value (a_value),
		.b_value (b_value)
	);

	slurm16_hazard_check hazard_check_i (
		.sel      (sel),
		.pend_ex  (pend_ex),
		.pend_mem (pend_mem),
		.stall    (stall)
	);

	slurm16_operand_latch operand_latch_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_ins    (in_ins),
		.a_value   (a_value),
		.b_value   (b_value),
		.stall     (stall),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_op    (out_op)
	);

endmodule

// ==== vlog.f ====
common/slurm16_pkg.sv
decode/slurm16_cpu_decode.sv
regfile/slurm16_register_file.sv
verilog/slurm16_hazard_check.sv
verilog/slurm16_operand_latch.sv
verilog/slurm16_operand_stage.sv
verification/slurm16_operand_checker.sv
verification/slurm16_operand_tb.sv
